//--- src/rename_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename stage sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register file
`define NUM_ARCH_REGS 32
`define ARCH_W        5
// hardwired zero, always reads ready
`define ZERO_REG      31

// physical tags backing the arch regs
`define NUM_PHYS_REGS 64
`define TAG_W         6

// one checkpoint per rob slot
`define NUM_ROB       8
`define ROB_W         3

`endif

//--- src/rename_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename side types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rename_cfg.svh"

package rename_pkg;

  // physical register tag
  typedef logic [`TAG_W-1:0]  tag_t;
  // architectural register index
  typedef logic [`ARCH_W-1:0] arch_idx_t;

  // one map slot, tag plus ready bit
  typedef struct packed {
    tag_t tag;
    logic ready;
  } map_entry_t;

  // request from decode
  typedef struct packed {
    logic               valid;
    arch_idx_t          dest;
    arch_idx_t          src_a;
    arch_idx_t          src_b;
    // slot the rob will give this instr
    logic [`ROB_W-1:0]  rob_tail;
  } rename_req_t;

  // result toward rob and reservation stations
  typedef struct packed {
    logic       valid;
    tag_t       t;
    tag_t       t_old;
    map_entry_t src_a;
    map_entry_t src_b;
  } rename_result_t;

endpackage

//--- src/rob_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rob side types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rename_cfg.svh"

package rob_pkg;

  // reorder buffer slot
  typedef logic [`ROB_W-1:0] rob_idx_t;

  // completion broadcast on the cdb
  typedef struct packed {
    logic               en;
    logic [`TAG_W-1:0]  tag;
    // arch reg the producer writes
    logic [`ARCH_W-1:0] dest;
  } cdb_pkt_t;

  // commit at rob head, frees the old tag
  typedef struct packed {
    logic              en;
    logic [`TAG_W-1:0] t_old;
  } retire_pkt_t;

  // squash back to a rob slot
  typedef struct packed {
    logic     en;
    rob_idx_t rob;
  } rollback_pkt_t;

endpackage

//--- src/map_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename map table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "rename_cfg.svh"

module map_table (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_en,
  input  rename_pkg::rename_req_t   req,
  input  rename_pkg::tag_t          new_tag,
  input  rob_pkg::cdb_pkt_t         cdb,
  input  rob_pkg::rollback_pkt_t    rollback,
  output rename_pkg::map_entry_t    t_old,
  output rename_pkg::map_entry_t    src_a,
  output rename_pkg::map_entry_t    src_b
);
  import rename_pkg::*;
  import rob_pkg::*;

  // whole arch to phys mapping
  typedef map_entry_t [`NUM_ARCH_REGS-1:0] map_t;

  map_t                   map_q;
  map_t                   map_d;
  map_t [`NUM_ROB-1:0]    ckpt_q;
  map_t [`NUM_ROB-1:0]    ckpt_d;
  map_t                   reset_map;
  rob_idx_t               ckpt_sel;

  // identity map, every reg ready
  always_comb begin
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      reset_map[i].tag   = tag_t'(i);
      reset_map[i].ready = 1'b1;
    end
  end

  // combinational reads straight from the current map
  assign t_old = map_q[req.dest];
  assign src_a = map_q[req.src_a];
  assign src_b = map_q[req.src_b];

  assign ckpt_sel = rollback.rob;

  // next map
  always_comb begin
    map_d = map_q;

    // squash, restore whole map from the slot
    if (rollback.en) begin
      map_d = ckpt_q[ckpt_sel];
    end

    // cdb wakeup
    // only if dest still maps to the broadcast tag,
    // otherwise a younger rename already replaced it
    if (cdb.en && (map_q[cdb.dest].tag == cdb.tag)) begin
      map_d[cdb.dest].ready = 1'b1;
    end

    // rename dest to the fresh tag, not ready yet
    if (dispatch_en) begin
      map_d[req.dest].tag   = new_tag;
      map_d[req.dest].ready = 1'b0;
      // zero reg never waits
      map_d[`ZERO_REG].ready = 1'b1;
    end
  end

  // next checkpoints
  always_comb begin
    ckpt_d = ckpt_q;

    if (dispatch_en) begin
      // snapshot includes this rename
      ckpt_d[req.rob_tail] = map_d;
      // everything older than a rollback target has completed by then
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        ckpt_d[req.rob_tail][i].ready = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q  <= reset_map;
      ckpt_q <= {`NUM_ROB{reset_map}};
    end else begin
      map_q  <= map_d;
      ckpt_q <= ckpt_d;
    end
  end

endmodule

//--- src/free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical tag free list
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "rename_cfg.svh"

module free_list (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_en,
  input  rob_pkg::rob_idx_t      rob_tail,
  input  rob_pkg::retire_pkt_t   retire,
  input  rob_pkg::rollback_pkt_t rollback,
  output rename_pkg::tag_t       head_tag,
  output logic                   empty
);
  import rename_pkg::*;
  import rob_pkg::*;

  localparam int DEPTH = `NUM_PHYS_REGS;
  // tags free right after reset
  localparam int INIT_FREE = `NUM_PHYS_REGS - `NUM_ARCH_REGS;

  // circular queue of free tags
  tag_t                queue_q [DEPTH];

  // pointers wrap naturally, depth is a power of two
  logic [`TAG_W-1:0]   head_q;
  logic [`TAG_W-1:0]   head_d;
  logic [`TAG_W-1:0]   head_inc;
  logic [`TAG_W-1:0]   tail_q;
  logic [`TAG_W-1:0]   tail_d;
  // 0..64 needs one extra bit
  logic [`TAG_W:0]     count_q;
  logic [`TAG_W:0]     count_d;

  // head after each dispatch, per rob slot
  logic [`TAG_W-1:0]   head_ckpt_q [`NUM_ROB];
  rob_idx_t            ckpt_sel;

  assign head_tag = queue_q[head_q];
  assign empty    = (count_q == '0);

  assign head_inc = head_q + 1'b1;
  assign ckpt_sel = rollback.rob;

  always_comb begin
    // tail only moves on retire, never rolled back
    tail_d = retire.en ? tail_q + 1'b1 : tail_q;

    if (rollback.en) begin
      head_d  = head_ckpt_q[ckpt_sel];
      // occupancy from pointers
      // full wrap cannot happen, arch regs always hold 32 tags
      count_d = {1'b0, tail_d - head_d};
    end else begin
      head_d  = dispatch_en ? head_inc : head_q;
      count_d = count_q + {{`TAG_W{1'b0}}, retire.en} - {{`TAG_W{1'b0}}, dispatch_en};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= `TAG_W'(INIT_FREE);
      count_q <= (`TAG_W+1)'(INIT_FREE);
      // slots 0..31 hold tags 32..63 in order
      for (int i = 0; i < DEPTH; i++) begin
        queue_q[i] <= tag_t'(i + `NUM_ARCH_REGS);
      end
      for (int r = 0; r < `NUM_ROB; r++) begin
        head_ckpt_q[r] <= '0;
      end
    end else begin
      head_q  <= head_d;
      tail_q  <= tail_d;
      count_q <= count_d;
      // retired tag goes back at the tail
      if (retire.en) begin
        queue_q[tail_q] <= retire.t_old;
      end
      // remember where the head went for this slot
      if (dispatch_en) begin
        head_ckpt_q[rob_tail] <= head_inc;
      end
    end
  end

endmodule

//--- src/rename_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename dispatch control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rename_dispatch (
  input  rename_pkg::rename_req_t    req,
  input  rob_pkg::rollback_pkt_t     rollback,
  input  rob_pkg::cdb_pkt_t          cdb,
  input  logic                       empty,
  input  rename_pkg::tag_t           head_tag,
  input  rename_pkg::map_entry_t     t_old,
  input  rename_pkg::map_entry_t     src_a_entry,
  input  rename_pkg::map_entry_t     src_b_entry,
  output logic                       dispatch_en,
  output logic                       stall,
  output rename_pkg::rename_result_t result
);
  import rename_pkg::*;
  import rob_pkg::*;

  map_entry_t src_a_byp;
  map_entry_t src_b_byp;

  // source whose producer completes this cycle reads as ready
  function automatic map_entry_t bypass(input map_entry_t entry, input cdb_pkt_t pkt);
    map_entry_t res;
    res = entry;
    if (pkt.en && (pkt.tag == entry.tag)) begin
      res.ready = 1'b1;
    end
    return res;
  endfunction

  // single dispatch decision for the stage
  // rollback wins over a request in the same cycle
  assign dispatch_en = req.valid && !empty && !rollback.en;

  // out of tags, source must hold the request
  assign stall = req.valid && empty;

  assign src_a_byp = bypass(src_a_entry, cdb);
  assign src_b_byp = bypass(src_b_entry, cdb);

  always_comb begin
    result.valid = dispatch_en;
    // new tag is whatever sits at the free head
    result.t     = head_tag;
    // old mapping goes to the rob, freed on retire
    result.t_old = t_old.tag;
    result.src_a = src_a_byp;
    result.src_b = src_b_byp;
  end

endmodule

//--- src/rename_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register rename stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rename_top (
  input  logic                       clock,
  input  logic                       reset,
  input  rename_pkg::rename_req_t    req,
  input  rob_pkg::cdb_pkt_t          cdb,
  input  rob_pkg::retire_pkt_t       retire,
  input  rob_pkg::rollback_pkt_t     rollback,
  output rename_pkg::rename_result_t result,
  output logic                       stall
);
  import rename_pkg::*;

  logic       dispatch_en;
  logic       empty;
  tag_t       head_tag;
  map_entry_t t_old_entry;
  map_entry_t src_a_entry;
  map_entry_t src_b_entry;

  // arch to phys mapping, ready bits, checkpoints
  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .req         (req),
    .new_tag     (head_tag),
    .cdb         (cdb),
    .rollback    (rollback),
    .t_old       (t_old_entry),
    .src_a       (src_a_entry),
    .src_b       (src_b_entry)
  );

  // free tag queue, head checkpoints
  free_list u_free_list (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .rob_tail    (req.rob_tail),
    .retire      (retire),
    .rollback    (rollback),
    .head_tag    (head_tag),
    .empty       (empty)
  );

  // go/stall and result assembly
  rename_dispatch u_rename_dispatch (
    .req         (req),
    .rollback    (rollback),
    .cdb         (cdb),
    .empty       (empty),
    .head_tag    (head_tag),
    .t_old       (t_old_entry),
    .src_a_entry (src_a_entry),
    .src_b_entry (src_b_entry),
    .dispatch_en (dispatch_en),
    .stall       (stall),
    .result      (result)
  );

endmodule

//--- verification/rename_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rename stage testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_tb;
  import rename_pkg::*;
  import rob_pkg::*;

  // room for 10 reset cycles and 2000 test cycles
  localparam int TIMEOUT_CYCLES = 2200;

  logic           clock;
  logic           reset;
  rename_req_t    req;
  cdb_pkt_t       cdb;
  retire_pkt_t    retire;
  rollback_pkt_t  rollback;
  rename_result_t result;
  logic           stall;

  // model of the map, its checkpoints and the free queue
  map_entry_t     m_map [`NUM_ARCH_REGS];
  map_entry_t     m_ckpt [`NUM_ROB][`NUM_ARCH_REGS];
  tag_t           m_fq [`NUM_PHYS_REGS];
  logic [5:0]     m_head;
  logic [5:0]     m_tail;
  logic [6:0]     m_count;
  logic [5:0]     m_hckpt [`NUM_ROB];

  // stimulus bookkeeping shared with the model
  cdb_pkt_t       pending_cdb [$];
  tag_t           pending_retire [$];
  logic [`NUM_ROB-1:0] used_slots;
  rob_idx_t       rob_next;
  logic           stall_hold;

  string          phase_name;
  int             cycle_count;
  int unsigned    seed_val;

  rename_top uut (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .cdb      (cdb),
    .retire   (retire),
    .rollback (rollback),
    .result   (result),
    .stall    (stall)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // expected result from the model state and this cycle's inputs
  function automatic rename_result_t expect_result(input rename_req_t r, input cdb_pkt_t c,
                                                   input rollback_pkt_t rb);
    rename_result_t res;
    res.valid = r.valid && (m_count != 0) && !rb.en;
    res.t     = m_fq[m_head];
    res.t_old = m_map[r.dest].tag;
    res.src_a = m_map[r.src_a];
    res.src_b = m_map[r.src_b];
    // same cycle cdb bypass
    if (c.en && (c.tag == res.src_a.tag)) begin
      res.src_a.ready = 1'b1;
    end
    if (c.en && (c.tag == res.src_b.tag)) begin
      res.src_b.ready = 1'b1;
    end
    return res;
  endfunction

  function automatic logic expect_stall(input rename_req_t r);
    return r.valid && (m_count == 0);
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      m_map[i].tag   = tag_t'(i);
      m_map[i].ready = 1'b1;
      for (int s = 0; s < `NUM_ROB; s++) begin
        m_ckpt[s][i] = m_map[i];
      end
    end
    // slot i holds tag i+32 modulo 64
    for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
      m_fq[i] = tag_t'((i + `NUM_ARCH_REGS) % `NUM_PHYS_REGS);
    end
    for (int s = 0; s < `NUM_ROB; s++) begin
      m_hckpt[s] = '0;
    end
    m_head     = '0;
    m_tail     = 6'd32;
    m_count    = 7'd32;
    used_slots = '0;
    rob_next   = '0;
    stall_hold = 1'b0;
    pending_cdb.delete();
    pending_retire.delete();
  endtask

  // state after the rising edge
  task automatic update_model(input rename_req_t r, input cdb_pkt_t c, input retire_pkt_t rt,
                              input rollback_pkt_t rb, input logic go);
    map_entry_t nmap [`NUM_ARCH_REGS];
    nmap = m_map;
    if (rb.en) begin
      nmap = m_ckpt[rb.rob];
    end
    // wakeup only while dest still maps to the tag
    if (c.en && (m_map[c.dest].tag == c.tag)) begin
      nmap[c.dest].ready = 1'b1;
    end
    if (go) begin
      nmap[r.dest].tag   = m_fq[m_head];
      nmap[r.dest].ready = 1'b0;
      nmap[`ZERO_REG].ready = 1'b1;
      m_ckpt[r.rob_tail] = nmap;
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        m_ckpt[r.rob_tail][i].ready = 1'b1;
      end
      m_hckpt[r.rob_tail] = m_head + 1'b1;
      pending_cdb.push_back({1'b1, m_fq[m_head], r.dest});
      pending_retire.push_back(m_map[r.dest].tag);
      used_slots[r.rob_tail] = 1'b1;
      rob_next = r.rob_tail + 1'b1;
    end
    m_map = nmap;
    // tail of the free queue never rolls back
    if (rt.en) begin
      m_fq[m_tail] = rt.t_old;
      m_tail = m_tail + 1'b1;
    end
    if (rb.en) begin
      m_head  = m_hckpt[rb.rob];
      m_count = {1'b0, m_tail - m_head};
      rob_next = rb.rob + 1'b1;
      // squashed work never completes or retires
      pending_cdb.delete();
      pending_retire.delete();
    end else begin
      if (go) begin
        m_head = m_head + 1'b1;
      end
      m_count = m_count + rt.en - go;
    end
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("mismatch in %s %s expected %h actual %h", phase_name, what, exp_val, act_val);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  // compare before the edge and then advance the model
  always @(posedge clock) begin
    rename_result_t exp_res;
    logic           exp_st;
    if (reset) begin
      reset_model();
    end else begin
      exp_res = expect_result(req, cdb, rollback);
      exp_st  = expect_stall(req);
      assert (result === exp_res) else report_mismatch("result", exp_res, result);
      assert (stall === exp_st) else report_mismatch("stall", exp_st, stall);
      // zero reg reads ready whatever happened before
      assert ((req.src_a != `ZERO_REG) || result.src_a.ready) else
        report_mismatch("zero reg src_a ready", 1, result.src_a.ready);
      assert ((req.src_b != `ZERO_REG) || result.src_b.ready) else
        report_mismatch("zero reg src_b ready", 1, result.src_b.ready);
      update_model(req, cdb, retire, rollback, exp_res.valid);
      stall_hold = exp_st;
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("error: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // one random cycle driven after the falling edge
  task automatic drive_random(input int p_req, input int p_cdb, input int p_ret,
                              input int p_rb);
    int pick;
    // stalled request stays on the bus
    if (!stall_hold) begin
      req.valid = (($urandom % 100) < p_req);
      req.dest  = arch_idx_t'($urandom % `NUM_ARCH_REGS);
      req.src_a = arch_idx_t'($urandom % `NUM_ARCH_REGS);
      req.src_b = arch_idx_t'($urandom % `NUM_ARCH_REGS);
    end
    req.rob_tail = rob_next;
    cdb      = '0;
    retire   = '0;
    rollback = '0;
    if ((used_slots != '0) && (($urandom % 100) < p_rb)) begin
      pick = $urandom % `NUM_ROB;
      while (!used_slots[pick]) begin
        pick = (pick + 1) % `NUM_ROB;
      end
      rollback.en  = 1'b1;
      rollback.rob = rob_idx_t'(pick);
    end else if ((pending_cdb.size() > 0) && (($urandom % 100) < p_cdb)) begin
      pick = $urandom % pending_cdb.size();
      cdb  = pending_cdb[pick];
      pending_cdb.delete(pick);
    end
    // retire in dispatch order
    if ((pending_retire.size() > 0) && (($urandom % 100) < p_ret)) begin
      retire.en    = 1'b1;
      retire.t_old = pending_retire.pop_front();
    end
  endtask

  task automatic run_phase(input string name, input int cycles, input int p_req,
                           input int p_cdb, input int p_ret, input int p_rb);
    phase_name = name;
    repeat (cycles) begin
      @(negedge clock);
      drive_random(p_req, p_cdb, p_ret, p_rb);
    end
  endtask

  initial begin
    seed_val    = $urandom(55396);
    cycle_count = 0;
    phase_name  = "reset";
    reset       = 1'b1;
    req         = '0;
    cdb         = '0;
    retire      = '0;
    rollback    = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;

    // read every register of the identity map
    phase_name = "reset_map";
    for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
      @(negedge clock);
      req.valid = 1'b0;
      req.dest  = arch_idx_t'(i);
      req.src_a = arch_idx_t'(i);
      req.src_b = arch_idx_t'(i);
    end

    // 32 tags then stall
    run_phase("alloc_order", 40, 100, 0, 0, 0);
    run_phase("wakeup", 128, 40, 70, 30, 0);
    run_phase("retire_reuse", 300, 70, 40, 60, 0);
    run_phase("rollback", 500, 60, 40, 50, 5);
    run_phase("random_mix", 1000, 50, 50, 50, 3);

    @(negedge clock);
    req      = '0;
    cdb      = '0;
    retire   = '0;
    rollback = '0;
    @(negedge clock);
    $display("sim passed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+src
src/rename_pkg.sv
src/rob_pkg.sv
src/map_table.sv
src/free_list.sv
src/rename_dispatch.sv
src/rename_top.sv
verification/rename_tb.sv

//--- Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - src

sources:
  - files:
      - src/rename_pkg.sv
      - src/rob_pkg.sv
      - src/map_table.sv
      - src/free_list.sv
      - src/rename_dispatch.sv
      - src/rename_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/rename_tb.sv
